/* Makefile */
# Verilator build and run for the RV32I core testbench
VERILATOR ?= verilator
TOP ?= rv32i_core_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --assert -j 0
PASS_TEXT ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass or fail comes from the log
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src.f */
verilog/core_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/immediate_extender.sv
verilog/dataflow.sv
verilog/control_unit.sv
verilog/rv32i_core.sv
tests/rv32i_core_assert.sv
tests/rv32i_core_tb.sv

/* tests/rv32i_core_assert.sv */
// Concurrent checks on the core's memory port and halt output, bound to the core top level
`timescale 1ns/1ps

module rv32i_core_assert (
  input logic                            clock,
  input logic                            reset,
  input logic [core_pkg::data_width-1:0] mem_addr,
  input logic                            mem_wr_en,
  input logic                            halted
);

  int unsigned failures = 0;

  // Quiet while in reset and for the first cycle out of it
  quiet_after_reset: assert property (
    @(posedge clock) $past(reset) |-> !mem_wr_en && !halted
  ) else begin
    $error("memory write or halt asserted during or right after reset");
    failures++;
  end

  // A store lasts one cycle
  single_cycle_store: assert property (
    @(posedge clock) disable iff (reset) mem_wr_en |=> !mem_wr_en
  ) else begin
    $error("mem_wr_en high for two consecutive cycles");
    failures++;
  end

  aligned_store: assert property (
    @(posedge clock) disable iff (reset) mem_wr_en |-> mem_addr[1:0] == 2'b00
  ) else begin
    $error("store to an unaligned address");
    failures++;
  end

  // Halt is sticky and blocks stores
  halt_holds: assert property (
    @(posedge clock) disable iff (reset) halted |=> halted && !mem_wr_en
  ) else begin
    $error("halted dropped or a store followed the halt");
    failures++;
  end

endmodule

bind rv32i_core rv32i_core_assert i_rv32i_core_assert (
  .clock     (clock),
  .reset     (reset),
  .mem_addr  (mem_addr),
  .mem_wr_en (mem_wr_en),
  .halted    (halted)
);

/* tests/rv32i_core_tb.sv */
// Testbench for the multicycle RV32I core running a self-checking program from a word memory
`timescale 1ns/1ps

module rv32i_core_tb;

  localparam int mem_words = 1024;
  localparam int reset_cycles = 10;
  localparam int data_base = 'h400;
  localparam int result_base = 'h600;
  localparam int result_index = result_base / 4;
  localparam logic [31:0] marker = 32'h000005a5;
  localparam logic [11:0] imm12 = 12'h9c3;
  localparam logic [31:0] imm32 = 32'hfffff9c3;

  logic        clock;
  logic        reset;
  logic [31:0] rd_data;
  logic [31:0] mem_addr;
  logic [31:0] wr_data;
  logic        mem_wr_en;
  logic        halted;

  logic [31:0] mem [0:mem_words-1];
  logic [31:0] image [0:mem_words-1];
  logic [31:0] expected [$];
  int unsigned prog_words;

  rv32i_core i_rv32i_core (
    .clock     (clock),
    .reset     (reset),
    .rd_data   (rd_data),
    .mem_addr  (mem_addr),
    .wr_data   (wr_data),
    .mem_wr_en (mem_wr_en),
    .halted    (halted)
  );

  always #10 clock = ~clock;

  // Image is copied in while reset is high
  always @(posedge clock) begin
    if (reset) begin
      mem <= image;
    end else if (mem_wr_en) begin
      mem[mem_addr[11:2]] <= wr_data;
    end
  end

  assign rd_data = mem[mem_addr[11:2]];

  function automatic logic [31:0] fill_word(int unsigned index);
    return (index * 32'h9e3779b9) ^ 32'h0848524e;
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Always a word store
  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::op_store};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::op_branch};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::op_jal};
  endfunction

  // Untouched value of the next result slot
  function automatic logic [31:0] next_fill();
    return fill_word(result_index + expected.size());
  endfunction

  task automatic emit(input logic [31:0] word);
    image[prog_words] = word;
    prog_words++;
  endtask

  // Stores rs2 into the next result slot through the base in x2
  task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
    emit(enc_s(12'(expected.size() * 4), rs2, 5'd2));
    expected.push_back(value);
  endtask

  // ALU result lands in x5
  task automatic alu_case(input logic [31:0] word, input logic [31:0] value);
    emit(word);
    store_result(5'd5, value);
  endtask

  // Taken branch skips the marker store
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] v1, input logic [31:0] v2);
    logic taken;
    case (f3)
      3'b000:  taken = v1 == v2;
      3'b001:  taken = v1 != v2;
      3'b100:  taken = $signed(v1) < $signed(v2);
      3'b101:  taken = $signed(v1) >= $signed(v2);
      3'b110:  taken = v1 < v2;
      default: taken = v1 >= v2;
    endcase
    emit(enc_b(13'd8, rs2, rs1, f3));
    store_result(5'd7, taken ? next_fill() : marker);
  endtask

  task automatic build_program(input logic [31:0] a, input logic [31:0] b, input logic [31:0] d);
    logic [2:0]  branch_conds [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [31:0] link;
    prog_words = 0;
    emit(enc_i(12'(data_base), 5'd0, 3'b000, 5'd1, core_pkg::op_imm));
    emit(enc_i(12'(result_base), 5'd0, 3'b000, 5'd2, core_pkg::op_imm));
    emit(enc_i(marker[11:0], 5'd0, 3'b000, 5'd7, core_pkg::op_imm));
    emit(enc_i(12'h000, 5'd1, 3'b010, 5'd3, core_pkg::op_load));
    emit(enc_i(12'h004, 5'd1, 3'b010, 5'd4, core_pkg::op_load));
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd5), a + b);
    alu_case(enc_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd5), a - b);
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b001, 5'd5), a << b[4:0]);
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd5), {31'b0, $signed(a) < $signed(b)});
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b011, 5'd5), {31'b0, a < b});
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd5), a ^ b);
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b101, 5'd5), a >> b[4:0]);
    alu_case(enc_r(7'h20, 5'd4, 5'd3, 3'b101, 5'd5), $signed(a) >>> b[4:0]);
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b110, 5'd5), a | b);
    alu_case(enc_r(7'h00, 5'd4, 5'd3, 3'b111, 5'd5), a & b);
    alu_case(enc_i(imm12, 5'd3, 3'b000, 5'd5, core_pkg::op_imm), a + imm32);
    alu_case(enc_i(imm12, 5'd3, 3'b010, 5'd5, core_pkg::op_imm),
             {31'b0, $signed(a) < $signed(imm32)});
    alu_case(enc_i(imm12, 5'd3, 3'b011, 5'd5, core_pkg::op_imm), {31'b0, a < imm32});
    alu_case(enc_i(imm12, 5'd3, 3'b100, 5'd5, core_pkg::op_imm), a ^ imm32);
    alu_case(enc_i(imm12, 5'd3, 3'b110, 5'd5, core_pkg::op_imm), a | imm32);
    alu_case(enc_i(imm12, 5'd3, 3'b111, 5'd5, core_pkg::op_imm), a & imm32);
    alu_case(enc_i(12'h007, 5'd3, 3'b001, 5'd5, core_pkg::op_imm), a << 7);
    alu_case(enc_i(12'h009, 5'd3, 3'b101, 5'd5, core_pkg::op_imm), a >> 9);
    alu_case(enc_i(12'h409, 5'd3, 3'b101, 5'd5, core_pkg::op_imm), $signed(a) >>> 9);
    alu_case(enc_u(20'habcde, 5'd5, core_pkg::op_lui), 32'habcde000);
    alu_case(enc_u(20'h12345, 5'd5, core_pkg::op_auipc), 32'(prog_words * 4) + 32'h12345000);
    // Load and copy, then a load into x0
    emit(enc_i(12'h008, 5'd1, 3'b010, 5'd6, core_pkg::op_load));
    store_result(5'd6, d);
    emit(enc_i(12'h008, 5'd1, 3'b010, 5'd0, core_pkg::op_load));
    store_result(5'd0, 32'h0);
    branch_case(3'b000, 5'd3, 5'd3, a, a);
    branch_case(3'b001, 5'd3, 5'd3, a, a);
    foreach (branch_conds[k]) begin
      branch_case(branch_conds[k], 5'd3, 5'd4, a, b);
      branch_case(branch_conds[k], 5'd4, 5'd3, b, a);
    end
    link = 32'(prog_words * 4) + 32'd4;
    emit(enc_j(21'd8, 5'd8));
    store_result(5'd7, next_fill());
    store_result(5'd8, link);
    // JALR target has bit 0 set before clearing
    link = 32'(prog_words * 4);
    emit(enc_u(20'h0, 5'd9, core_pkg::op_auipc));
    emit(enc_i(12'd13, 5'd9, 3'b000, 5'd10, core_pkg::op_jalr));
    store_result(5'd7, next_fill());
    store_result(5'd10, link + 32'd8);
    emit(32'h00000073);
    store_result(5'd7, next_fill());
  endtask

  task automatic check_word(input int unsigned index, input logic [31:0] value);
    assert (mem[index] === value) else begin
      $display("mismatch mem[%h]: expected %h got %h", index * 4, value, mem[index]);
      $display("Test failed");
      $fatal(1, "result word check failed");
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    clock = 1'b0;
    reset = 1'b1;
    a = $urandom(32'h0848524e);
    b = $urandom();
    d = $urandom();
    for (int i = 0; i < mem_words; i++) begin
      image[i] = fill_word(i);
    end
    image[data_base / 4] = a;
    image[data_base / 4 + 1] = b;
    image[data_base / 4 + 2] = d;
    build_program(a, b, d);
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    wait (halted);
    repeat (4) @(negedge clock);
    for (int i = 0; i < expected.size(); i++) begin
      check_word(result_index + i, expected[i]);
    end
    if (i_rv32i_core.i_rv32i_core_assert.failures == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", i_rv32i_core.i_rv32i_core_assert.failures);
      $display("Test failed");
      $fatal(1, "bound assertion failures");
    end
  end

  // A bound assertion failure ends the run at the next falling edge
  always @(negedge clock) begin
    if (i_rv32i_core.i_rv32i_core_assert.failures != 0) begin
      $display("Test failed");
      $fatal(1, "bound assertion failed");
    end
  end

  // Watchdog sized from the program length
  initial begin
    int unsigned limit;
    @(negedge clock);
    limit = reset_cycles + prog_words * 4 + 100;
    repeat (limit) @(posedge clock);
    $display("timeout: core did not halt within %0d cycles", limit);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* verilog/alu.sv */
// ALU with add/subtract, shifts, compares and logic ops, plus flags from the adder
`timescale 1ns/1ps

module alu (
  input  logic [core_pkg::data_width-1:0] a,
  input  logic [core_pkg::data_width-1:0] b,
  input  core_pkg::alu_op_e               alu_op,
  input  logic                            sub,
  input  logic                            arithmetic,
  output logic [core_pkg::data_width-1:0] y,
  output core_pkg::flags_t                flags
);

  logic [core_pkg::data_width-1:0] b_eff;
  logic [core_pkg::data_width-1:0] sum;
  logic                            carry;
  logic [$clog2(core_pkg::data_width)-1:0] shamt;

  // Two's complement subtract as a + ~b + 1
  assign b_eff = sub ? ~b : b;
  assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{core_pkg::data_width{1'b0}}, sub};
  assign shamt = b[$clog2(core_pkg::data_width)-1:0];

  assign flags.zero      = ~|sum;
  assign flags.negative  = sum[core_pkg::data_width-1];
  assign flags.carry_out = carry;
  assign flags.overflow  = (a[core_pkg::data_width-1] == b_eff[core_pkg::data_width-1]) &&
                           (sum[core_pkg::data_width-1] != a[core_pkg::data_width-1]);

  always_comb begin
    case (alu_op)
      core_pkg::alu_add:  y = sum;
      core_pkg::alu_sll:  y = a << shamt;
      // Compares rely on sub being set by the control unit
      core_pkg::alu_slt:  y = {{(core_pkg::data_width-1){1'b0}}, flags.negative ^ flags.overflow};
      core_pkg::alu_sltu: y = {{(core_pkg::data_width-1){1'b0}}, ~carry};
      core_pkg::alu_xor:  y = a ^ b;
      core_pkg::alu_srl: begin
        if (arithmetic) begin
          y = $signed(a) >>> shamt;
        end else begin
          y = a >> shamt;
        end
      end
      core_pkg::alu_or:   y = a | b;
      core_pkg::alu_and:  y = a & b;
      default:            y = sum;
    endcase
  end

endmodule

/* verilog/control_unit.sv */
// Multicycle control unit with fetch, execute, memory and halt states and branch evaluation
`timescale 1ns/1ps

module control_unit (
  input  logic              clock,
  input  logic              reset,
  input  core_pkg::decode_t decode,
  input  core_pkg::flags_t  flags,
  output core_pkg::ctrl_t   ctrl,
  output logic              mem_wr_en,
  output logic              halted
);

  typedef enum logic [1:0] {
    st_fetch,
    st_execute,
    st_memory,
    st_halt
  } state_e;

  state_e state;
  state_e state_next;
  logic   branch_taken;
  logic   illegal;
  logic   alu_funct_op;
  logic   is_compare;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_fetch;
    end else begin
      state <= state_next;
    end
  end

  // Conditions from rs1 - rs2
  always_comb begin
    case (decode.funct3)
      3'b000:  branch_taken = flags.zero;
      3'b001:  branch_taken = ~flags.zero;
      3'b100:  branch_taken = flags.negative ^ flags.overflow;
      3'b101:  branch_taken = ~(flags.negative ^ flags.overflow);
      3'b110:  branch_taken = ~flags.carry_out;
      3'b111:  branch_taken = flags.carry_out;
      default: branch_taken = 1'b0;
    endcase
  end

  // ECALL, EBREAK, sub-word accesses and unknown opcodes stop the core
  always_comb begin
    case (decode.opcode)
      core_pkg::op_lui, core_pkg::op_auipc, core_pkg::op_jal: illegal = 1'b0;
      core_pkg::op_imm, core_pkg::op_reg:                     illegal = 1'b0;
      core_pkg::op_jalr:   illegal = decode.funct3 != 3'b000;
      core_pkg::op_branch: illegal = decode.funct3[2:1] == 2'b01;
      core_pkg::op_load, core_pkg::op_store: illegal = decode.funct3 != 3'b010;
      default:             illegal = 1'b1;
    endcase
  end

  assign alu_funct_op = (decode.opcode == core_pkg::op_imm) ||
                        (decode.opcode == core_pkg::op_reg);
  assign is_compare   = (decode.funct3 == core_pkg::alu_slt) ||
                        (decode.funct3 == core_pkg::alu_sltu);

  always_comb begin
    ctrl       = '0;
    mem_wr_en  = 1'b0;
    state_next = state;

    // Operand and function selects follow the decoded instruction
    ctrl.alua_src   = decode.opcode == core_pkg::op_auipc;
    ctrl.alub_src   = (decode.opcode != core_pkg::op_reg) &&
                      (decode.opcode != core_pkg::op_branch);
    ctrl.alu_op     = alu_funct_op ? core_pkg::alu_op_e'(decode.funct3) : core_pkg::alu_add;
    ctrl.sub        = (decode.opcode == core_pkg::op_branch) ||
                      (alu_funct_op && is_compare) ||
                      ((decode.opcode == core_pkg::op_reg) && (decode.funct3 == 3'b000) &&
                       decode.funct7[5]);
    ctrl.arithmetic = alu_funct_op && (decode.funct3 == 3'b101) && decode.funct7[5];
    ctrl.alupc_src  = decode.opcode == core_pkg::op_jalr;
    if ((decode.opcode == core_pkg::op_jal) || (decode.opcode == core_pkg::op_jalr)) begin
      ctrl.wr_reg_src = core_pkg::wb_pc_plus_4;
    end else if (decode.opcode == core_pkg::op_load) begin
      ctrl.wr_reg_src = core_pkg::wb_mem;
    end else begin
      ctrl.wr_reg_src = core_pkg::wb_alu;
    end

    // Enables per state
    case (state)
      st_fetch: begin
        ctrl.ir_en = 1'b1;
        state_next = st_execute;
      end
      st_execute: begin
        if (illegal) begin
          state_next = st_halt;
        end else if ((decode.opcode == core_pkg::op_load) ||
                     (decode.opcode == core_pkg::op_store)) begin
          state_next = st_memory;
        end else begin
          ctrl.pc_src    = (decode.opcode == core_pkg::op_jal) ||
                           (decode.opcode == core_pkg::op_jalr) ||
                           ((decode.opcode == core_pkg::op_branch) && branch_taken);
          ctrl.pc_en     = 1'b1;
          ctrl.wr_reg_en = decode.opcode != core_pkg::op_branch;
          state_next     = st_fetch;
        end
      end
      st_memory: begin
        ctrl.mem_addr_src = 1'b1;
        ctrl.pc_en        = 1'b1;
        ctrl.wr_reg_en    = decode.opcode == core_pkg::op_load;
        mem_wr_en         = decode.opcode == core_pkg::op_store;
        state_next        = st_fetch;
      end
      default: begin
        state_next = st_halt;
      end
    endcase
  end

  assign halted = state == st_halt;

endmodule

/* verilog/core_pkg.sv */
// Core package with data path widths, RV32I opcode and ALU encodings and the shared structs
package core_pkg;

  localparam int data_width = 32;
  localparam int reg_addr_width = 5;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  // Same encoding as funct3 of the ALU instructions
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_e;

  // Write-back source, bit 1 picks the non-ALU sources
  typedef enum logic [1:0] {
    wb_alu       = 2'b00,
    wb_mem       = 2'b10,
    wb_pc_plus_4 = 2'b11
  } wr_reg_src_e;

  typedef struct packed {
    logic        alua_src;
    logic        alub_src;
    alu_op_e     alu_op;
    logic        sub;
    logic        arithmetic;
    logic        alupc_src;
    logic        pc_src;
    logic        pc_en;
    wr_reg_src_e wr_reg_src;
    logic        wr_reg_en;
    logic        ir_en;
    logic        mem_addr_src;
  } ctrl_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry_out;
    logic overflow;
  } flags_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
  } decode_t;

endpackage

/* verilog/dataflow.sv */
// RV32I dataflow with IR, PC, target adder, register file, immediate extender, ALU and muxes
`timescale 1ns/1ps

module dataflow (
  input  logic                            clock,
  input  logic                            reset,
  input  core_pkg::ctrl_t                 ctrl,
  input  logic [core_pkg::data_width-1:0] rd_data,
  output logic [core_pkg::data_width-1:0] wr_data,
  output logic [core_pkg::data_width-1:0] mem_addr,
  output core_pkg::decode_t               decode,
  output core_pkg::flags_t                flags
);

  logic [31:0]                         ir;
  logic [core_pkg::data_width-1:0]     pc;
  logic [core_pkg::data_width-1:0]     pc_next;
  logic [core_pkg::data_width-1:0]     pc_plus_4;
  logic [core_pkg::data_width-1:0]     target_base;
  logic [core_pkg::data_width-1:0]     target_sum;
  logic [core_pkg::reg_addr_width-1:0] rs1_addr;
  logic [core_pkg::data_width-1:0]     rs1;
  logic [core_pkg::data_width-1:0]     rs2;
  logic [core_pkg::data_width-1:0]     rd_value;
  logic [core_pkg::data_width-1:0]     immediate;
  logic [core_pkg::data_width-1:0]     alu_a;
  logic [core_pkg::data_width-1:0]     alu_b;
  logic [core_pkg::data_width-1:0]     alu_y;

  // Instruction register, loaded straight from the memory read port
  always_ff @(posedge clock) begin
    if (reset) begin
      ir <= '0;
    end else if (ctrl.ir_en) begin
      ir <= rd_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.pc_en) begin
      pc <= pc_next;
    end
  end

  // PC + 4 and branch/jump target
  assign pc_plus_4   = pc + core_pkg::data_width'(4);
  assign target_base = ctrl.alupc_src ? rs1 : pc;
  assign target_sum  = target_base + immediate;
  // Bit 0 cleared for JALR, already zero for branches and JAL
  assign pc_next = ctrl.pc_src ? {target_sum[core_pkg::data_width-1:1], 1'b0} : pc_plus_4;

  // LUI reads x0 so the ALU passes the immediate through
  assign rs1_addr = (ir[6:0] == core_pkg::op_lui) ? '0 : ir[19:15];

  always_comb begin
    case (ctrl.wr_reg_src)
      core_pkg::wb_mem:       rd_value = rd_data;
      core_pkg::wb_pc_plus_4: rd_value = pc_plus_4;
      default:                rd_value = alu_y;
    endcase
  end

  register_file i_register_file (
    .clock         (clock),
    .reset         (reset),
    .write_enable  (ctrl.wr_reg_en),
    .read_address1 (rs1_addr),
    .read_address2 (ir[24:20]),
    .write_address (ir[11:7]),
    .write_data    (rd_value),
    .read_data1    (rs1),
    .read_data2    (rs2)
  );

  immediate_extender i_immediate_extender (
    .instruction (ir),
    .immediate   (immediate)
  );

  assign alu_a = ctrl.alua_src ? pc : rs1;
  assign alu_b = ctrl.alub_src ? immediate : rs2;

  alu i_alu (
    .a          (alu_a),
    .b          (alu_b),
    .alu_op     (ctrl.alu_op),
    .sub        (ctrl.sub),
    .arithmetic (ctrl.arithmetic),
    .y          (alu_y),
    .flags      (flags)
  );

  assign mem_addr = ctrl.mem_addr_src ? alu_y : pc;
  assign wr_data  = rs2;

  assign decode.opcode = core_pkg::opcode_e'(ir[6:0]);
  assign decode.funct3 = ir[14:12];
  assign decode.funct7 = ir[31:25];

endmodule

/* verilog/immediate_extender.sv */
// Immediate extender that builds the sign-extended I, S, B, U or J immediate of an instruction
`timescale 1ns/1ps

module immediate_extender (
  input  logic [31:0]                     instruction,
  output logic [core_pkg::data_width-1:0] immediate
);

  logic sign;

  assign sign = instruction[31];

  always_comb begin
    case (core_pkg::opcode_e'(instruction[6:0]))
      core_pkg::op_store: begin
        immediate = {{(core_pkg::data_width-12){sign}}, instruction[31:25], instruction[11:7]};
      end
      core_pkg::op_branch: begin
        immediate = {{(core_pkg::data_width-13){sign}}, instruction[31], instruction[7],
                     instruction[30:25], instruction[11:8], 1'b0};
      end
      core_pkg::op_lui, core_pkg::op_auipc: begin
        immediate = {{(core_pkg::data_width-32){sign}}, instruction[31:12], 12'b0};
      end
      core_pkg::op_jal: begin
        immediate = {{(core_pkg::data_width-21){sign}}, instruction[31], instruction[19:12],
                     instruction[20], instruction[30:21], 1'b0};
      end
      // JALR, loads, register-immediate ops and anything else
      default: begin
        immediate = {{(core_pkg::data_width-12){sign}}, instruction[31:20]};
      end
    endcase
  end

endmodule

/* verilog/register_file.sv */
// Integer register file with two asynchronous reads, one synchronous write and x0 tied to zero
`timescale 1ns/1ps

module register_file (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                write_enable,
  input  logic [core_pkg::reg_addr_width-1:0] read_address1,
  input  logic [core_pkg::reg_addr_width-1:0] read_address2,
  input  logic [core_pkg::reg_addr_width-1:0] write_address,
  input  logic [core_pkg::data_width-1:0]     write_data,
  output logic [core_pkg::data_width-1:0]     read_data1,
  output logic [core_pkg::data_width-1:0]     read_data2
);

  // x0 has no storage
  logic [core_pkg::data_width-1:0] regs [1:(2**core_pkg::reg_addr_width)-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 2**core_pkg::reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_address != '0)) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
  assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

/* verilog/rv32i_core.sv */
// Multicycle RV32I core joining the dataflow and the control unit behind one memory port
`timescale 1ns/1ps

module rv32i_core (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [core_pkg::data_width-1:0] rd_data,
  output logic [core_pkg::data_width-1:0] mem_addr,
  output logic [core_pkg::data_width-1:0] wr_data,
  output logic                            mem_wr_en,
  output logic                            halted
);

  core_pkg::ctrl_t   ctrl;
  core_pkg::decode_t decode;
  core_pkg::flags_t  flags;

  dataflow i_dataflow (
    .clock    (clock),
    .reset    (reset),
    .ctrl     (ctrl),
    .rd_data  (rd_data),
    .wr_data  (wr_data),
    .mem_addr (mem_addr),
    .decode   (decode),
    .flags    (flags)
  );

  control_unit i_control_unit (
    .clock     (clock),
    .reset     (reset),
    .decode    (decode),
    .flags     (flags),
    .ctrl      (ctrl),
    .mem_wr_en (mem_wr_en),
    .halted    (halted)
  );

endmodule
